/* all.f */
+incdir+verification
common/pn_pkg.sv
rtl/token_buffer.sv
rtl/operand_stack.sv
rtl/eval_ctrl.sv
rtl/pn_alu.sv
result/sort4_network.sv
result/result_collector.sv
rtl/pn_evaluator.sv
verification/tb_pn_evaluator.sv

/* verification/pn_tests.svh */
// Directed evaluator tests
`ifndef PN_TESTS_SVH
`define PN_TESTS_SVH

task automatic reset_outputs_low();
    repeat (5) begin
        @(negedge clk);
        check_level(out_valid, 1'b0, "out_valid after reset");
        check_result(out, '0, "out after reset");
    end
endtask

task automatic postfix_single();
    add_operand(3);
    add_operand(4);
    add_operator(pn_pkg::op_add);
    add_operand(2);
    add_operator(pn_pkg::op_mul);
    expect_value(14);
    run_string(pn_pkg::postfix, "postfix 3 4 + 2 *");
    add_operand(2);
    add_operand(7);
    add_operator(pn_pkg::op_sub);
    expect_value(-5);
    run_string(pn_pkg::postfix, "postfix 2 7 -");
endtask

// Subtraction stays left minus right
task automatic prefix_single();
    add_operator(pn_pkg::op_sub);
    add_operand(2);
    add_operand(7);
    expect_value(-5);
    run_string(pn_pkg::prefix, "prefix - 2 7");
    add_operator(pn_pkg::op_mul);
    add_operator(pn_pkg::op_add);
    add_operand(3);
    add_operand(4);
    add_operand(2);
    expect_value(14);
    run_string(pn_pkg::prefix, "prefix * + 3 4 2");
endtask

task automatic abs_sum_and_wrap();
    // |(2-7) + (1-6)|
    add_operand(2);
    add_operand(7);
    add_operator(pn_pkg::op_sub);
    add_operand(1);
    add_operand(6);
    add_operator(pn_pkg::op_sub);
    add_operator(pn_pkg::op_abs_sum);
    expect_value(10);
    run_string(pn_pkg::postfix, "abs of negative sum");
    // 7^6 wraps to -13423
    add_operand(7);
    for (int i = 0; i < 5; i++) begin
        add_operand(7);
        add_operator(pn_pkg::op_mul);
    end
    expect_value(-13423);
    run_string(pn_pkg::postfix, "multiply chain");
endtask

task automatic burst_ordering();
    // 7, -5, 30, 8 sorted ascending
    add_operand(3);
    add_operand(4);
    add_operator(pn_pkg::op_add);
    add_operand(2);
    add_operand(7);
    add_operator(pn_pkg::op_sub);
    add_operand(5);
    add_operand(6);
    add_operator(pn_pkg::op_mul);
    add_operand(1);
    add_operand(7);
    add_operator(pn_pkg::op_abs_sum);
    expect_value(-5);
    expect_value(7);
    expect_value(8);
    expect_value(30);
    run_string(pn_pkg::postfix_burst, "postfix burst of four");
    // -5, 9, 2, 7 sorted descending
    add_operator(pn_pkg::op_sub);
    add_operand(1);
    add_operand(6);
    add_operator(pn_pkg::op_mul);
    add_operand(3);
    add_operand(3);
    add_operator(pn_pkg::op_add);
    add_operand(0);
    add_operand(2);
    add_operator(pn_pkg::op_abs_sum);
    add_operand(7);
    add_operand(0);
    expect_value(9);
    expect_value(7);
    expect_value(2);
    expect_value(-5);
    run_string(pn_pkg::prefix_burst, "prefix burst of four");
    add_operand(6);
    add_operand(6);
    add_operator(pn_pkg::op_mul);
    add_operand(0);
    add_operand(5);
    add_operator(pn_pkg::op_sub);
    expect_value(-5);
    expect_value(36);
    run_string(pn_pkg::postfix_burst, "postfix burst of two");
endtask

// Prefix strings are built back to front from a postfix-shaped sequence
task automatic random_strings();
    int               operands_left;
    int               operators_left;
    int               depth;
    pn_pkg::token_t   t;
    pn_pkg::pn_mode_e m;
    for (int s = 0; s < 20; s++) begin
        m              = (s % 2 == 0) ? pn_pkg::postfix : pn_pkg::prefix;
        operands_left  = 2 + ($unsigned($random(seed)) % 7);
        operators_left = operands_left - 1;
        depth          = 0;
        while (operands_left + operators_left > 0) begin
            if (depth >= 2 && operators_left > 0 &&
                (operands_left == 0 || ($random(seed) & 1) != 0)) begin
                t = '{is_operator: 1'b1, value: pn_pkg::operand_w'($random(seed) & 3)};
                operators_left--;
                depth--;
            end else begin
                t = '{is_operator: 1'b0, value: pn_pkg::operand_w'($random(seed))};
                operands_left--;
                depth++;
            end
            if (m == pn_pkg::prefix) begin
                str_q.push_front(t);
            end else begin
                str_q.push_back(t);
            end
        end
        model_evaluate(m);
        run_string(m, $sformatf("random string %0d", s));
    end
endtask

`endif

/* verification/tb_pn_evaluator.sv */
// Evaluator testbench
`timescale 1ns/1ps
`default_nettype none

module tb_pn_evaluator;

    // Each string sent counts as one test
    localparam int num_tests   = 30;
    localparam int cycle_ns    = 40;
    localparam int watchdog_ns = num_tests * 200 * cycle_ns;
    localparam int max_wait    = 200;

    logic                         clk;
    logic                         rst_n;
    logic [1:0]                   mode;
    logic                         operator;
    logic [pn_pkg::operand_w-1:0] in;
    logic                         in_valid;
    logic                         out_valid;
    pn_pkg::result_t              out;

    pn_pkg::token_t  str_q[$];
    pn_pkg::result_t exp_q[$];
    integer          seed;

    pn_evaluator pn_evaluator_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .mode      (mode),
        .operator  (operator),
        .in        (in),
        .in_valid  (in_valid),
        .out_valid (out_valid),
        .out       (out)
    );

    initial begin
        clk = 1'b0;
        forever #(cycle_ns / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired before the tests finished");
        $display("Some tests failed");
        $fatal(1, "Watchdog timeout");
    end

    // =========================================================================
    // Error reporting and compare tasks
    // =========================================================================
    task automatic report_error(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1, "Stopping after the first error");
    endtask

    task automatic check_result(input pn_pkg::result_t got, input pn_pkg::result_t exp,
                                input string what);
        if (got !== exp) begin
            report_error($sformatf("FAIL at %0t ns: %s expected %0d, got %0d",
                                   $time, what, exp, got));
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("FAIL at %0t ns: %s expected %b, got %b",
                                   $time, what, exp, got));
        end
    endtask

    // =========================================================================
    // String building and reference model
    // =========================================================================
    task automatic add_operand(input int v);
        str_q.push_back('{is_operator: 1'b0, value: pn_pkg::operand_w'(v)});
    endtask

    task automatic add_operator(input pn_pkg::pn_op_e op);
        str_q.push_back('{is_operator: 1'b1, value: pn_pkg::operand_w'(op)});
    endtask

    task automatic expect_value(input int v);
        exp_q.push_back(pn_pkg::result_t'(v));
    endtask

    // Left operand op right operand, wrapped to 16 bits
    function automatic pn_pkg::result_t apply_op(input pn_pkg::pn_op_e op, input int a,
                                                 input int b);
        int s;
        s = int'(pn_pkg::result_t'(a + b));
        case (op)
            pn_pkg::op_add: return pn_pkg::result_t'(a + b);
            pn_pkg::op_sub: return pn_pkg::result_t'(a - b);
            pn_pkg::op_mul: return pn_pkg::result_t'(a * b);
            default:        return pn_pkg::result_t'((s < 0) ? -s : s);
        endcase
    endfunction

    // Single-expression stack evaluator
    task automatic model_evaluate(input pn_pkg::pn_mode_e m);
        pn_pkg::result_t stack[$];
        pn_pkg::result_t left_v;
        pn_pkg::result_t right_v;
        pn_pkg::token_t  t;
        logic            reverse;
        reverse = (m == pn_pkg::prefix);
        exp_q.delete();
        for (int n = 0; n < str_q.size(); n++) begin
            t = reverse ? str_q[str_q.size() - 1 - n] : str_q[n];
            if (!t.is_operator) begin
                stack.push_back(pn_pkg::result_t'(t.value));
            end else if (reverse) begin
                left_v  = stack.pop_back();
                right_v = stack.pop_back();
                stack.push_back(apply_op(pn_pkg::pn_op_e'(t.value[1:0]), left_v, right_v));
            end else begin
                right_v = stack.pop_back();
                left_v  = stack.pop_back();
                stack.push_back(apply_op(pn_pkg::pn_op_e'(t.value[1:0]), left_v, right_v));
            end
        end
        exp_q.push_back(stack.pop_back());
    endtask

    // =========================================================================
    // Send a string, collect the output burst, compare
    // =========================================================================
    task automatic run_string(input pn_pkg::pn_mode_e m, input string name);
        int wait_cycles;
        foreach (str_q[i]) begin
            @(posedge clk);
            #2;
            mode     = m;
            in_valid = 1'b1;
            operator = str_q[i].is_operator;
            in       = str_q[i].value;
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        operator = 1'b0;
        in       = '0;

        wait_cycles = 0;
        @(negedge clk);
        while (!out_valid) begin
            check_result(out, '0, {name, " idle out"});
            wait_cycles++;
            if (wait_cycles > max_wait) begin
                report_error($sformatf("Timed out waiting for out_valid on %s", name));
            end
            @(negedge clk);
        end
        // Results must come on consecutive cycles
        foreach (exp_q[i]) begin
            check_level(out_valid, 1'b1, $sformatf("%s out_valid for result %0d", name, i));
            check_result(out, exp_q[i], $sformatf("%s result %0d", name, i));
            @(negedge clk);
        end
        check_level(out_valid, 1'b0, {name, " out_valid after the results"});
        check_result(out, '0, {name, " out after the results"});
        @(negedge clk);
        check_level(out_valid, 1'b0, {name, " out_valid after the burst"});
        str_q.delete();
        exp_q.delete();
    endtask

    `include "pn_tests.svh"

    initial begin
        rst_n    = 1'b0;
        mode     = 2'd0;
        operator = 1'b0;
        in       = '0;
        in_valid = 1'b0;
        seed     = 32'h4f86_5db0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;

        reset_outputs_low();
        postfix_single();
        prefix_single();
        abs_sum_and_wrap();
        burst_ordering();
        random_strings();

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/pn_evaluator.sv */
// Polish notation evaluator top
`timescale 1ns/1ps
`default_nettype none

module pn_evaluator (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire [1:0]                   mode,
    input  wire                         operator,
    input  wire [pn_pkg::operand_w-1:0] in,
    input  wire                         in_valid,
    output logic                        out_valid,
    output pn_pkg::result_t             out
);

    pn_pkg::token_t       in_token;
    pn_pkg::token_t       token;
    logic                 at_last;
    pn_pkg::scan_cmd_t    scan;
    pn_pkg::stack_cmd_t   stack_cmd;
    pn_pkg::alu_cmd_t     alu_cmd;
    pn_pkg::collect_cmd_t collect;
    pn_pkg::result_t      stack_top;
    pn_pkg::result_t      alu_result;
    logic                 emit_done;

    assign in_token = '{is_operator: operator, value: in};

    token_buffer token_buffer_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_token (in_token),
        .scan     (scan),
        .token    (token),
        .at_last  (at_last)
    );

    operand_stack operand_stack_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (stack_cmd),
        .top   (stack_top)
    );

    eval_ctrl eval_ctrl_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .mode       (pn_pkg::pn_mode_e'(mode)),
        .token      (token),
        .at_last    (at_last),
        .alu_result (alu_result),
        .emit_done  (emit_done),
        .scan       (scan),
        .stack_cmd  (stack_cmd),
        .alu_cmd    (alu_cmd),
        .collect    (collect)
    );

    pn_alu pn_alu_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (alu_cmd),
        .stack_top (stack_top),
        .result    (alu_result)
    );

    result_collector result_collector_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (collect),
        .alu_result (alu_result),
        .out        (out),
        .out_valid  (out_valid),
        .emit_done  (emit_done)
    );

endmodule

`default_nettype wire

/* result/result_collector.sv */
// Result buffer and sorted output
`timescale 1ns/1ps
`default_nettype none

module result_collector (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire pn_pkg::collect_cmd_t  cmd,
    input  wire pn_pkg::result_t       alu_result,
    output pn_pkg::result_t            out,
    output logic                       out_valid,
    output logic                       emit_done
);

    pn_pkg::result_t                 slots    [pn_pkg::max_results];
    pn_pkg::result_t                 sorted   [pn_pkg::max_results];
    pn_pkg::result_t                 sorted_q [pn_pkg::max_results];
    logic [pn_pkg::result_cnt_w-1:0] count;
    logic [pn_pkg::result_cnt_w-1:0] last_slot;
    logic [pn_pkg::result_cnt_w-1:0] left;
    logic [pn_pkg::result_idx_w-1:0] rd_idx;
    logic                            active;
    logic                            desc_q;

    assign last_slot = count - 1'b1;

    always_ff @(posedge clk) begin
        if (cmd.clear) begin
            for (int i = 0; i < pn_pkg::max_results; i++) begin
                slots[i] <= pn_pkg::result_fill;
            end
        end else if (cmd.record && count < pn_pkg::max_results) begin
            slots[count[pn_pkg::result_idx_w-1:0]] <= alu_result;
        end
        if (cmd.emit_start) begin
            sorted_q <= sorted;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (cmd.clear) begin
            count <= '0;
        end else if (cmd.record && count < pn_pkg::max_results) begin
            count <= count + 1'b1;
        end
    end

    sort4_network sort4_network_inst (
        .in_vals (slots),
        .sorted  (sorted)
    );

    // =========================================================================
    // Output sequencing
    // =========================================================================
    // Fill values sit above the real results, so descending starts at count-1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            left   <= '0;
            rd_idx <= '0;
            desc_q <= 1'b0;
        end else if (cmd.emit_start) begin
            active <= (count != 0);
            left   <= count;
            desc_q <= cmd.descending;
            rd_idx <= cmd.descending ? last_slot[pn_pkg::result_idx_w-1:0] : '0;
        end else if (active) begin
            left   <= left - 1'b1;
            rd_idx <= desc_q ? rd_idx - 1'b1 : rd_idx + 1'b1;
            if (left == 1) begin
                active <= 1'b0;
            end
        end
    end

    assign out_valid = active;
    assign out       = active ? sorted_q[rd_idx] : '0;
    assign emit_done = active && (left == 1);

endmodule

`default_nettype wire

/* result/sort4_network.sv */
// Four-input sorting network
`timescale 1ns/1ps
`default_nettype none

module sort4_network (
    input  wire pn_pkg::result_t in_vals [4],
    output pn_pkg::result_t      sorted  [4]
);

    pn_pkg::result_t s1 [4];
    pn_pkg::result_t s2 [4];

    // Returns {min, max} of two signed values
    function automatic logic [2*pn_pkg::result_w-1:0] exchange(
        input pn_pkg::result_t a,
        input pn_pkg::result_t b
    );
        return (a > b) ? {b, a} : {a, b};
    endfunction

    always_comb begin
        // Sort pairs
        {s1[0], s1[1]} = exchange(in_vals[0], in_vals[1]);
        {s1[2], s1[3]} = exchange(in_vals[2], in_vals[3]);
        // Global min and max
        {s2[0], s2[2]} = exchange(s1[0], s1[2]);
        {s2[1], s2[3]} = exchange(s1[1], s1[3]);
        // Middle pair
        {sorted[1], sorted[2]} = exchange(s2[1], s2[2]);
        sorted[0] = s2[0];
        sorted[3] = s2[3];
    end

endmodule

`default_nettype wire

/* rtl/pn_alu.sv */
// Operand registers and arithmetic
`timescale 1ns/1ps
`default_nettype none

module pn_alu (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire pn_pkg::alu_cmd_t  cmd,
    input  wire pn_pkg::result_t   stack_top,
    output pn_pkg::result_t        result
);

    pn_pkg::result_t first_q;
    pn_pkg::result_t second_q;
    pn_pkg::result_t sum;
    pn_pkg::pn_op_e  op_q;
    logic            postfix_q;

    always_ff @(posedge clk) begin
        if (cmd.load_first) begin
            first_q <= stack_top;
        end
        if (cmd.load_second) begin
            second_q <= stack_top;
        end
    end

    // Operation held with the operands, stable through push_result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q      <= pn_pkg::op_add;
            postfix_q <= 1'b0;
        end else if (cmd.load_second) begin
            op_q      <= cmd.op;
            postfix_q <= cmd.postfix;
        end
    end

    assign sum = first_q + second_q;

    // All results wrap at result_w bits
    always_comb begin
        case (op_q)
            pn_pkg::op_add: result = sum;
            pn_pkg::op_sub: result = postfix_q ? second_q - first_q : first_q - second_q;
            pn_pkg::op_mul: result = first_q * second_q;
            default:        result = sum[pn_pkg::result_w-1] ? -sum : sum;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/eval_ctrl.sv */
// Evaluation controller
`timescale 1ns/1ps
`default_nettype none

module eval_ctrl (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        in_valid,
    input  wire pn_pkg::pn_mode_e      mode,
    input  wire pn_pkg::token_t        token,
    input  wire                        at_last,
    input  wire pn_pkg::result_t       alu_result,
    input  wire                        emit_done,
    output pn_pkg::scan_cmd_t          scan,
    output pn_pkg::stack_cmd_t         stack_cmd,
    output pn_pkg::alu_cmd_t           alu_cmd,
    output pn_pkg::collect_cmd_t       collect
);

    pn_pkg::main_state_e state;
    pn_pkg::main_state_e state_next;
    pn_pkg::stack_step_e step;
    pn_pkg::stack_step_e step_next;
    pn_pkg::pn_mode_e    mode_q;
    logic                emit_started;
    logic                burst;
    logic                postfix_scan;
    logic                final_calc;

    assign burst        = (mode_q == pn_pkg::prefix_burst) || (mode_q == pn_pkg::postfix_burst);
    assign postfix_scan = (mode_q == pn_pkg::postfix) || (mode_q == pn_pkg::postfix_burst);
    assign final_calc   = (state == pn_pkg::evaluate) && (step == pn_pkg::calculate) && at_last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= pn_pkg::idle;
            step         <= pn_pkg::classify;
            mode_q       <= pn_pkg::postfix;
            emit_started <= 1'b0;
        end else begin
            state        <= state_next;
            step         <= step_next;
            emit_started <= (state == pn_pkg::emit);
            // Mode comes with the first token
            if (state == pn_pkg::idle && in_valid) begin
                mode_q <= mode;
            end
        end
    end

    // =========================================================================
    // Main sequence
    // =========================================================================
    always_comb begin
        state_next = state;
        case (state)
            pn_pkg::idle:     if (in_valid) state_next = pn_pkg::read;
            pn_pkg::read:     if (!in_valid) state_next = pn_pkg::evaluate;
            pn_pkg::evaluate: if (final_calc) state_next = pn_pkg::emit;
            pn_pkg::emit:     if (emit_done) state_next = pn_pkg::idle;
            default:          state_next = pn_pkg::idle;
        endcase
    end

    // =========================================================================
    // Per-token stack steps
    // =========================================================================
    always_comb begin
        step_next = pn_pkg::classify;
        if (state == pn_pkg::evaluate) begin
            case (step)
                pn_pkg::classify: begin
                    step_next = token.is_operator ? pn_pkg::pop_first : pn_pkg::push_operand;
                end
                pn_pkg::pop_first:  step_next = pn_pkg::pop_second;
                pn_pkg::pop_second: step_next = pn_pkg::calculate;
                pn_pkg::calculate: begin
                    // Burst results never go back on the stack
                    if (!burst && !at_last) begin
                        step_next = pn_pkg::push_result;
                    end
                end
                default: step_next = pn_pkg::classify;
            endcase
        end
    end

    always_comb begin
        scan      = '0;
        stack_cmd = '0;
        alu_cmd   = '0;
        collect   = '0;

        scan.reverse       = !postfix_scan;
        scan.start         = (state == pn_pkg::read) && !in_valid;
        collect.clear      = scan.start;
        collect.descending = (mode_q == pn_pkg::prefix_burst);
        collect.emit_start = (state == pn_pkg::emit) && !emit_started;
        alu_cmd.op         = pn_pkg::pn_op_e'(token.value[1:0]);
        alu_cmd.postfix    = postfix_scan;

        if (state == pn_pkg::evaluate) begin
            case (step)
                pn_pkg::push_operand: begin
                    stack_cmd.push      = 1'b1;
                    stack_cmd.push_data = pn_pkg::result_t'(token.value);
                    scan.step           = 1'b1;
                end
                pn_pkg::pop_first: begin
                    stack_cmd.pop      = 1'b1;
                    alu_cmd.load_first = 1'b1;
                end
                pn_pkg::pop_second: begin
                    stack_cmd.pop       = 1'b1;
                    alu_cmd.load_second = 1'b1;
                end
                pn_pkg::calculate: begin
                    scan.step      = 1'b1;
                    collect.record = burst || at_last;
                end
                pn_pkg::push_result: begin
                    stack_cmd.push      = 1'b1;
                    stack_cmd.push_data = alu_result;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/operand_stack.sv */
// Operand stack
`timescale 1ns/1ps
`default_nettype none

module operand_stack (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire pn_pkg::stack_cmd_t  cmd,
    output pn_pkg::result_t          top
);

    pn_pkg::result_t                mem [pn_pkg::stack_depth];
    logic [pn_pkg::stack_ptr_w-1:0] sp;

    always_ff @(posedge clk) begin
        if (cmd.push) begin
            mem[sp] <= cmd.push_data;
        end
    end

    // sp points at the next free word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sp <= '0;
        end else if (cmd.push) begin
            sp <= sp + 1'b1;
        end else if (cmd.pop) begin
            sp <= sp - 1'b1;
        end
    end

    assign top = mem[sp - 1'b1];

endmodule

`default_nettype wire

/* rtl/token_buffer.sv */
// Token storage and scan
`timescale 1ns/1ps
`default_nettype none

module token_buffer (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     in_valid,
    input  wire pn_pkg::token_t     in_token,
    input  wire pn_pkg::scan_cmd_t  scan,
    output pn_pkg::token_t          token,
    output logic                    at_last
);

    pn_pkg::token_t               tokens [pn_pkg::buf_depth];
    logic [pn_pkg::buf_idx_w-1:0] length;
    logic [pn_pkg::buf_idx_w-1:0] idx;
    logic [pn_pkg::buf_idx_w-1:0] end_idx;

    always_ff @(posedge clk) begin
        if (in_valid) begin
            tokens[length] <= in_token;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            length <= '0;
        end else if (scan.start) begin
            length <= '0;
        end else if (in_valid) begin
            length <= length + 1'b1;
        end
    end

    // Start at one end of the string, finish at the other
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx     <= '0;
            end_idx <= '0;
        end else if (scan.start) begin
            idx     <= scan.reverse ? length - 1'b1 : '0;
            end_idx <= scan.reverse ? '0 : length - 1'b1;
        end else if (scan.step) begin
            idx <= scan.reverse ? idx - 1'b1 : idx + 1'b1;
        end
    end

    assign token   = tokens[idx];
    assign at_last = (idx == end_idx);

endmodule

`default_nettype wire

/* common/pn_pkg.sv */
// Polish notation evaluator package
`default_nettype none

package pn_pkg;

    // =========================================================================
    // Widths and depths
    // =========================================================================
    localparam int result_w     = 16;
    localparam int operand_w    = 3;
    localparam int buf_depth    = 16;
    localparam int buf_idx_w    = 4;
    localparam int stack_depth  = 16;
    localparam int stack_ptr_w  = $clog2(stack_depth);
    localparam int max_results  = 4;
    localparam int result_cnt_w = $clog2(max_results + 1);
    localparam int result_idx_w = $clog2(max_results);

    typedef logic signed [result_w-1:0] result_t;

    // Largest positive value so that empty slots sort last
    localparam result_t result_fill = {1'b0, {(result_w - 1){1'b1}}};

    // =========================================================================
    // Encodings
    // =========================================================================
    // Same codes as the mode input
    typedef enum logic [1:0] {
        prefix_burst  = 2'd0,
        postfix_burst = 2'd1,
        prefix        = 2'd2,
        postfix       = 2'd3
    } pn_mode_e;

    // Low two bits of an operator token
    typedef enum logic [1:0] {
        op_add     = 2'd0,
        op_sub     = 2'd1,
        op_mul     = 2'd2,
        op_abs_sum = 2'd3
    } pn_op_e;

    typedef enum logic [1:0] {
        idle,
        read,
        evaluate,
        emit
    } main_state_e;

    typedef enum logic [2:0] {
        classify,
        push_operand,
        pop_first,
        pop_second,
        calculate,
        push_result
    } stack_step_e;

    // =========================================================================
    // Tokens and block commands
    // =========================================================================
    typedef struct packed {
        logic                 is_operator;
        logic [operand_w-1:0] value;
    } token_t;

    typedef struct packed {
        logic start;
        logic step;
        logic reverse;
    } scan_cmd_t;

    typedef struct packed {
        logic    push;
        logic    pop;
        result_t push_data;
    } stack_cmd_t;

    typedef struct packed {
        logic   load_first;
        logic   load_second;
        pn_op_e op;
        logic   postfix;
    } alu_cmd_t;

    typedef struct packed {
        logic clear;
        logic record;
        logic emit_start;
        logic descending;
    } collect_cmd_t;

endpackage

`default_nettype wire
